// File: sim.f
+incdir+tb
src/mpram_pkg.sv
src/read_port.sv
src/write_port.sv
src/mpram_4r1w.sv
src/access_error_log.sv
src/mpram_top.sv
tb/tb_mpram.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the register file testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mpram -Mdir obj_dir -f sim.f

./obj_dir/Vtb_mpram | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
   echo "simulation ok"
else
   echo "simulation reported failure"
   exit 1
fi

// File: tb/mpram_ref_model.svh
`ifndef MPRAM_REF_MODEL_SVH
`define MPRAM_REF_MODEL_SVH

// Reference model of the register file and its error log.
// It is stepped once per rising edge with the inputs sampled at that edge.
mpram_pkg::data_t    model_mem [mpram_pkg::WORDS];
mpram_pkg::data_t    exp_dout [mpram_pkg::RD_PORTS];
logic [3:0]          exp_valid;
logic [3:0]          pend_rd_err;
logic                pend_wr_err;
mpram_pkg::err_cnt_t exp_count;
logic                exp_sticky;
mpram_pkg::err_src_t exp_src;

function automatic bit addr_ok(input mpram_pkg::addr_t a);
   return a < mpram_pkg::addr_t'(mpram_pkg::WORDS);
endfunction

// Lowest read port first, the write port last.
function automatic mpram_pkg::err_src_t first_source(input logic [3:0] rd);
   if (rd[0])
      return 3'd0;
   else if (rd[1])
      return 3'd1;
   else if (rd[2])
      return 3'd2;
   else if (rd[3])
      return 3'd3;
   return 3'd4;
endfunction

function automatic void model_reset();
   foreach (model_mem[w])
      model_mem[w] = '0;
   foreach (exp_dout[p])
      exp_dout[p] = '0;
   exp_valid   = '0;
   pend_rd_err = '0;
   pend_wr_err = 1'b0;
   exp_count   = '0;
   exp_sticky  = 1'b0;
   exp_src     = '0;
endfunction

function automatic void model_step(input mpram_pkg::addr_t ra [mpram_pkg::RD_PORTS],
                                   input logic [3:0] oe, input mpram_pkg::addr_t wa,
                                   input logic we, input mpram_pkg::data_t wd,
                                   input logic clr);
   logic [8:0] sum;
   // The log sees the pulses that were registered at the previous edge.
   sum = {1'b0, exp_count} + 9'(pend_wr_err) + 9'(pend_rd_err[0]) + 9'(pend_rd_err[1])
         + 9'(pend_rd_err[2]) + 9'(pend_rd_err[3]);
   if (clr)
   begin
      exp_count  = '0;
      exp_sticky = 1'b0;
      exp_src    = '0;
   end
   else if (pend_wr_err || (|pend_rd_err))
   begin
      exp_count = sum[8] ? 8'hff : sum[7:0];
      if (!exp_sticky)
         exp_src = first_source(pend_rd_err);
      exp_sticky = 1'b1;
   end
   // The write lands before the reads look up, which gives write-first.
   pend_wr_err = !we && !addr_ok(wa);
   if (!we && addr_ok(wa))
      model_mem[wa] = wd;
   for (int p = 0; p < mpram_pkg::RD_PORTS; p++)
   begin
      exp_valid[p]   = !oe[p] && addr_ok(ra[p]);
      pend_rd_err[p] = !oe[p] && !addr_ok(ra[p]);
      if (exp_valid[p])
         exp_dout[p] = model_mem[ra[p]];
      else if (pend_rd_err[p])
         exp_dout[p] = '0;
   end
endfunction

`endif

// File: tb/tb_mpram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mpram;

   localparam int MIXED_LEN = 400;
   localparam int SAT_LEN   = 60;
   localparam int HOLD_LEN  = 40;
   // Cycles of all tests together, reset included.
   localparam int TOTAL_CYCLES = 2 + 8 + (2 * mpram_pkg::WORDS + 1) + (MIXED_LEN + 1)
                                 + (SAT_LEN + 29) + (HOLD_LEN + 1) + 12;

   logic                clk;
   logic                rst_n;
   mpram_pkg::addr_t    rad [mpram_pkg::RD_PORTS];
   logic [3:0]          oe_n;
   mpram_pkg::addr_t    wad;
   logic                we_n;
   mpram_pkg::data_t    din;
   logic                err_clear;
   mpram_pkg::data_t    dout [mpram_pkg::RD_PORTS];
   logic [3:0]          dout_valid;
   mpram_pkg::err_cnt_t err_count;
   logic                err_sticky;
   mpram_pkg::err_src_t err_src;
   int                  seed;
   int                  check_count;
   int                  error_count;
   int                  tests_failed;
   int                  test_errors_at_start;

   `include "mpram_ref_model.svh"

   mpram_top mpram_top_inst
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .rad0        (rad[0]),
      .rad1        (rad[1]),
      .rad2        (rad[2]),
      .rad3        (rad[3]),
      .oe0_n       (oe_n[0]),
      .oe1_n       (oe_n[1]),
      .oe2_n       (oe_n[2]),
      .oe3_n       (oe_n[3]),
      .wad         (wad),
      .we_n        (we_n),
      .din         (din),
      .dout0       (dout[0]),
      .dout1       (dout[1]),
      .dout2       (dout[2]),
      .dout3       (dout[3]),
      .dout_valid0 (dout_valid[0]),
      .dout_valid1 (dout_valid[1]),
      .dout_valid2 (dout_valid[2]),
      .dout_valid3 (dout_valid[3]),
      .err_clear   (err_clear),
      .err_count   (err_count),
      .err_sticky  (err_sticky),
      .err_src     (err_src)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      #(TOTAL_CYCLES * 4 * 2);
      $display("timeout, the tests did not finish within %0d cycles", TOTAL_CYCLES * 2);
      $display("*** TEST FAILED ***");
      $finish;
   end

   function automatic logic [31:0] rand_bits();
      return $random(seed);
   endfunction

   function automatic int rand_below(input int n);
      return int'(rand_bits() % 32'(n));
   endfunction

   // Unmapped codes 24 to 31 when bad is set.
   function automatic mpram_pkg::addr_t rand_addr(input bit bad);
      if (bad)
         return mpram_pkg::addr_t'(mpram_pkg::WORDS + rand_below(32 - mpram_pkg::WORDS));
      return mpram_pkg::addr_t'(rand_below(mpram_pkg::WORDS));
   endfunction

   task automatic check_value(input string name, input logic [7:0] exp_v,
                              input logic [7:0] act_v);
      check_count++;
      assert (act_v === exp_v)
      else
      begin
         error_count++;
         $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, exp_v, act_v);
      end
   endtask

   task automatic check_outputs();
      for (int p = 0; p < mpram_pkg::RD_PORTS; p++)
      begin
         check_value($sformatf("dout%0d", p), 8'(exp_dout[p]), 8'(dout[p]));
         check_value($sformatf("dout_valid%0d", p), 8'(exp_valid[p]), 8'(dout_valid[p]));
      end
      check_value("err_count", exp_count, err_count);
      check_value("err_sticky", 8'(exp_sticky), 8'(err_sticky));
      check_value("err_src", 8'(exp_src), 8'(err_src));
   endtask

   // Inputs are set before the call, on a falling edge.
   task automatic cycle();
      @(posedge clk);
      model_step(rad, oe_n, wad, we_n, din, err_clear);
      #1;
      check_outputs();
      @(negedge clk);
   endtask

   task automatic set_idle();
      oe_n      = '1;
      we_n      = 1'b1;
      err_clear = 1'b0;
   endtask

   task automatic read_all();
      for (int w = 0; w < mpram_pkg::WORDS; w += mpram_pkg::RD_PORTS)
      begin
         for (int p = 0; p < mpram_pkg::RD_PORTS; p++)
         begin
            rad[p]  = mpram_pkg::addr_t'(w + p);
            oe_n[p] = 1'b0;
         end
         cycle();
      end
      set_idle();
   endtask

   task automatic random_cycles(input int n, input int we_pct, input int off_pct,
                                input int bad_pct, input int hit_pct);
      for (int c = 0; c < n; c++)
      begin
         we_n = rand_below(100) >= we_pct;
         wad  = rand_addr(rand_below(100) < bad_pct);
         din  = mpram_pkg::data_t'(rand_bits());
         for (int p = 0; p < mpram_pkg::RD_PORTS; p++)
         begin
            oe_n[p] = rand_below(100) < off_pct;
            rad[p]  = rand_addr(rand_below(100) < bad_pct);
            // Some reads aim at the word being written.
            if (rand_below(100) < hit_pct)
               rad[p] = wad;
         end
         cycle();
      end
      set_idle();
   endtask

   task automatic end_test(input int num, input string name);
      if (error_count == test_errors_at_start)
         $display("test %0d %s: ok", num, name);
      else
      begin
         tests_failed++;
         $display("test %0d %s: %0d errors", num, name, error_count - test_errors_at_start);
      end
      test_errors_at_start = error_count;
   endtask

   initial
   begin
      int port;
      seed                 = 32'h3c70_d3f1;
      check_count          = 0;
      error_count          = 0;
      tests_failed         = 0;
      test_errors_at_start = 0;
      rst_n                = 1'b0;
      wad                  = '0;
      din                  = '0;
      for (int p = 0; p < mpram_pkg::RD_PORTS; p++)
         rad[p] = '0;
      set_idle();
      model_reset();
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      cycle();
      read_all();
      cycle();
      end_test(1, "reset state");

      for (int w = 0; w < mpram_pkg::WORDS; w++)
      begin
         we_n = 1'b0;
         wad  = mpram_pkg::addr_t'(w);
         din  = mpram_pkg::data_t'(rand_bits());
         cycle();
      end
      set_idle();
      for (int w = 0; w < mpram_pkg::WORDS; w++)
      begin
         port       = rand_below(mpram_pkg::RD_PORTS);
         rad[port]  = mpram_pkg::addr_t'(w);
         oe_n[port] = 1'b0;
         cycle();
         set_idle();
      end
      cycle();
      end_test(2, "fill and read back");

      random_cycles(MIXED_LEN, 60, 25, 20, 25);
      cycle();
      end_test(3, "mixed traffic");

      err_clear = 1'b1;
      cycle();
      err_clear = 1'b0;
      random_cycles(20, 50, 25, 50, 0);
      // every port and the write port out of range, enough to saturate
      random_cycles(SAT_LEN, 100, 0, 100, 0);
      read_all();
      repeat (2) cycle();
      end_test(4, "out of range accesses");

      random_cycles(HOLD_LEN, 0, 50, 0, 0);
      cycle();
      end_test(5, "disabled port hold");

      // Pulses pending on the clear edge are dropped by the log.
      we_n    = 1'b0;
      wad     = rand_addr(1'b1);
      rad[3]  = rand_addr(1'b1);
      oe_n[3] = 1'b0;
      cycle();
      set_idle();
      err_clear = 1'b1;
      cycle();
      err_clear = 1'b0;
      we_n      = 1'b0;
      wad       = rand_addr(1'b1);
      cycle();
      set_idle();
      repeat (2) cycle();
      rad[1]  = rand_addr(1'b1);
      rad[2]  = rand_addr(1'b1);
      oe_n[1] = 1'b0;
      oe_n[2] = 1'b0;
      cycle();
      set_idle();
      repeat (2) cycle();
      err_clear = 1'b1;
      cycle();
      err_clear = 1'b0;
      we_n      = 1'b0;
      wad       = rand_addr(1'b1);
      rad[1]    = rand_addr(1'b1);
      oe_n[1]   = 1'b0;
      cycle();
      set_idle();
      repeat (2) cycle();
      end_test(6, "error log clear");

      $display("6 tests, %0d failed, %0d checks, %0d errors", tests_failed, check_count,
               error_count);
      if (error_count == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: src/mpram_top.sv
`timescale 1ns/1ps
`default_nettype none

// Pin-level top: register file plus its error log.
module mpram_top
(
   input  logic                clk,
   input  logic                rst_n,
   input  mpram_pkg::addr_t    rad0,
   input  mpram_pkg::addr_t    rad1,
   input  mpram_pkg::addr_t    rad2,
   input  mpram_pkg::addr_t    rad3,
   input  logic                oe0_n,
   input  logic                oe1_n,
   input  logic                oe2_n,
   input  logic                oe3_n,
   input  mpram_pkg::addr_t    wad,
   input  logic                we_n,
   input  mpram_pkg::data_t    din,
   output mpram_pkg::data_t    dout0,
   output mpram_pkg::data_t    dout1,
   output mpram_pkg::data_t    dout2,
   output mpram_pkg::data_t    dout3,
   output logic                dout_valid0,
   output logic                dout_valid1,
   output logic                dout_valid2,
   output logic                dout_valid3,
   input  logic                err_clear,
   output mpram_pkg::err_cnt_t err_count,
   output logic                err_sticky,
   output mpram_pkg::err_src_t err_src
);

   logic [mpram_pkg::RD_PORTS-1:0] rd_err;
   logic                           wr_err;

   mpram_4r1w mpram_4r1w_inst
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .rad0        (rad0),
      .rad1        (rad1),
      .rad2        (rad2),
      .rad3        (rad3),
      .oe0_n       (oe0_n),
      .oe1_n       (oe1_n),
      .oe2_n       (oe2_n),
      .oe3_n       (oe3_n),
      .wad         (wad),
      .we_n        (we_n),
      .din         (din),
      .dout0       (dout0),
      .dout1       (dout1),
      .dout2       (dout2),
      .dout3       (dout3),
      .dout_valid0 (dout_valid0),
      .dout_valid1 (dout_valid1),
      .dout_valid2 (dout_valid2),
      .dout_valid3 (dout_valid3),
      .rd_err      (rd_err),
      .wr_err      (wr_err)
   );

   access_error_log access_error_log_inst
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_err     (rd_err),
      .wr_err     (wr_err),
      .err_clear  (err_clear),
      .err_count  (err_count),
      .err_sticky (err_sticky),
      .err_src    (err_src)
   );

endmodule

`default_nettype wire

// File: src/access_error_log.sv
`timescale 1ns/1ps
`default_nettype none

// Collects read and write range errors.
// Saturating count, sticky flag, and the source of the first error.
module access_error_log
(
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [mpram_pkg::RD_PORTS-1:0] rd_err,
   input  logic                           wr_err,
   input  logic                           err_clear,
   output mpram_pkg::err_cnt_t            err_count,
   output logic                           err_sticky,
   output mpram_pkg::err_src_t            err_src
);

   logic [2:0]                    n_err;
   logic [mpram_pkg::ERR_CNT_W:0] sum;
   mpram_pkg::err_src_t           first_src;
   logic                          any_err;

   // Pulses this cycle, at most five.
   always_comb
   begin
      n_err = {2'b00, wr_err};
      for (int i = 0; i < mpram_pkg::RD_PORTS; i++)
         n_err = n_err + {2'b00, rd_err[i]};
   end

   assign sum     = {1'b0, err_count} + {{(mpram_pkg::ERR_CNT_W - 2){1'b0}}, n_err};
   assign any_err = wr_err || (|rd_err);

   // Lowest-numbered source wins, the write port is last.
   always_comb
   begin
      first_src = mpram_pkg::err_src_t'(mpram_pkg::RD_PORTS);
      for (int i = mpram_pkg::RD_PORTS - 1; i >= 0; i--)
         if (rd_err[i])
            first_src = mpram_pkg::err_src_t'(i);
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         err_count  <= '0;
         err_sticky <= 1'b0;
         err_src    <= '0;
      end
      else if (err_clear)
      begin
         err_count  <= '0;
         err_sticky <= 1'b0;
         err_src    <= '0;
      end
      else if (any_err)
      begin
         err_count <= sum[mpram_pkg::ERR_CNT_W] ? '1 : sum[mpram_pkg::ERR_CNT_W-1:0];
         if (!err_sticky)
         begin
            err_sticky <= 1'b1;
            err_src    <= first_src;
         end
      end
   end

   // Only a clear can bring the count down.
   a_count_monotonic : assert property (
      @(posedge clk) disable iff (!rst_n)
      (err_count < $past(err_count)) |-> $past(err_clear)
   );

endmodule

`default_nettype wire

// File: src/mpram_4r1w.sv
`timescale 1ns/1ps
`default_nettype none

// Register file with four registered read ports and one write port.
// Write-first: a read sampled on a write edge to the same word gets the new data.
module mpram_4r1w
(
   input  logic                            clk,
   input  logic                            rst_n,
   input  mpram_pkg::addr_t                rad0,
   input  mpram_pkg::addr_t                rad1,
   input  mpram_pkg::addr_t                rad2,
   input  mpram_pkg::addr_t                rad3,
   input  logic                            oe0_n,
   input  logic                            oe1_n,
   input  logic                            oe2_n,
   input  logic                            oe3_n,
   input  mpram_pkg::addr_t                wad,
   input  logic                            we_n,
   input  mpram_pkg::data_t                din,
   output mpram_pkg::data_t                dout0,
   output mpram_pkg::data_t                dout1,
   output mpram_pkg::data_t                dout2,
   output mpram_pkg::data_t                dout3,
   output logic                            dout_valid0,
   output logic                            dout_valid1,
   output logic                            dout_valid2,
   output logic                            dout_valid3,
   output logic [mpram_pkg::RD_PORTS-1:0]  rd_err,
   output logic                            wr_err
);

   mpram_pkg::data_t mem [mpram_pkg::WORDS];

   logic             wr_en;
   mpram_pkg::addr_t wr_addr;
   mpram_pkg::data_t wr_data;

   // Per-port views of the loose pins.
   mpram_pkg::addr_t              rad   [mpram_pkg::RD_PORTS];
   mpram_pkg::data_t              rdata [mpram_pkg::RD_PORTS];
   mpram_pkg::data_t              dout  [mpram_pkg::RD_PORTS];
   logic [mpram_pkg::RD_PORTS-1:0] oe_n;
   logic [mpram_pkg::RD_PORTS-1:0] dout_valid;

   assign rad[0] = rad0;
   assign rad[1] = rad1;
   assign rad[2] = rad2;
   assign rad[3] = rad3;
   assign oe_n   = {oe3_n, oe2_n, oe1_n, oe0_n};

   assign dout0       = dout[0];
   assign dout1       = dout[1];
   assign dout2       = dout[2];
   assign dout3       = dout[3];
   assign dout_valid0 = dout_valid[0];
   assign dout_valid1 = dout_valid[1];
   assign dout_valid2 = dout_valid[2];
   assign dout_valid3 = dout_valid[3];

   write_port write_port_inst
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_n    (we_n),
      .addr    (wad),
      .din     (din),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .wr_err  (wr_err)
   );

   // Storage, cleared at reset.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int w = 0; w < mpram_pkg::WORDS; w++)
            mem[w] <= '0;
      end
      else if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

   generate
      for (genvar i = 0; i < mpram_pkg::RD_PORTS; i++)
      begin : g_rd
         // Bypass the write data when this port hits the word being written.
         assign rdata[i] = (wr_en && (wr_addr == rad[i])) ? wr_data : mem[rad[i]];

         read_port read_port_inst
         (
            .clk        (clk),
            .rst_n      (rst_n),
            .oe_n       (oe_n[i]),
            .addr       (rad[i]),
            .mem_data   (rdata[i]),
            .dout       (dout[i]),
            .dout_valid (dout_valid[i]),
            .addr_err   (rd_err[i])
         );
      end
   endgenerate

   // The write port must never hand the array an unknown address.
   a_wr_addr_known : assert property (
      @(posedge clk) disable iff (!rst_n)
      wr_en |-> !$isunknown(wr_addr)
   );

endmodule

`default_nettype wire

// File: src/write_port.sv
`timescale 1ns/1ps
`default_nettype none

// The single write port.
// Qualifies the external strobe so that only legal words are written.
module write_port
(
   input  logic             clk,
   input  logic             rst_n,
   input  logic             we_n,
   input  mpram_pkg::addr_t addr,
   input  mpram_pkg::data_t din,
   output logic             wr_en,
   output mpram_pkg::addr_t wr_addr,
   output mpram_pkg::data_t wr_data,
   output logic             wr_err
);

   logic in_range;
   logic wr_drop;

   assign in_range = (addr < mpram_pkg::addr_t'(mpram_pkg::WORDS));

   // The array write happens on the same edge the strobe is sampled.
   assign wr_en   = !we_n && in_range;
   assign wr_addr = addr;
   assign wr_data = din;

   // Requested write that falls outside the array.
   assign wr_drop = !we_n && !in_range;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_err <= 1'b0;
      end
      else
      begin
         wr_err <= wr_drop;
      end
   end

   // Only legal words ever reach the array.
   a_wr_in_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      wr_en |-> (wr_addr < mpram_pkg::addr_t'(mpram_pkg::WORDS))
   );

endmodule

`default_nettype wire

// File: src/read_port.sv
`timescale 1ns/1ps
`default_nettype none

// One registered read port.
// The lookup word arrives already bypassed from the write path.
module read_port
(
   input  logic             clk,
   input  logic             rst_n,
   input  logic             oe_n,
   input  mpram_pkg::addr_t addr,
   input  mpram_pkg::data_t mem_data,
   output mpram_pkg::data_t dout,
   output logic             dout_valid,
   output logic             addr_err
);

   logic in_range;

   // Address codes at or above WORDS have no storage behind them.
   assign in_range = (addr < mpram_pkg::addr_t'(mpram_pkg::WORDS));

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dout       <= '0;
         dout_valid <= 1'b0;
         addr_err   <= 1'b0;
      end
      else if (!oe_n)
      begin
         if (in_range)
         begin
            dout       <= mem_data;
            dout_valid <= 1'b1;
            addr_err   <= 1'b0;
         end
         else
         begin
            // An out-of-range address returns zero and flags it for one cycle.
            dout       <= '0;
            dout_valid <= 1'b0;
            addr_err   <= 1'b1;
         end
      end
      else
      begin
         // Disabled port keeps its last word.
         dout_valid <= 1'b0;
         addr_err   <= 1'b0;
      end
   end

   // A sampled access is never both valid and in error.
   a_valid_err_excl : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(addr_err && dout_valid)
   );

endmodule

`default_nettype wire

// File: src/mpram_pkg.sv
`default_nettype none

// Shared widths and types for the 4-read, 1-write register file.
package mpram_pkg;

   // Word and address widths.
   localparam int DATA_W = 4;
   localparam int ADDR_W = 5;

   // Only the first 24 address codes map to storage.
   // Codes 24 to 31 are out of range.
   localparam int WORDS = 24;

   // Number of read ports.
   localparam int RD_PORTS = 4;

   // Width of the saturating error counter.
   localparam int ERR_CNT_W = 8;

   // One stored word.
   typedef logic [DATA_W-1:0] data_t;

   // A read or write address.
   typedef logic [ADDR_W-1:0] addr_t;

   // Saturating count of access errors.
   typedef logic [ERR_CNT_W-1:0] err_cnt_t;

   // Error source code.
   // 0 to 3 are read ports 0 to 3, 4 (RD_PORTS) is the write port.
   typedef logic [2:0] err_src_t;

endpackage

`default_nettype wire
